// File: apple2_disk_hub.f
+incdir+rtl
rtl/apple2_disk_pkg.sv
rtl/drive_status_router.sv
rtl/drive_request_channel.sv
rtl/sd_host_mux.sv
rtl/apple2_disk_hub.sv
dv/tb_apple2_disk_hub.sv

// File: dv/tb_apple2_disk_hub.sv
// Apple II disk hub testbench
// Drives mounts and CPU sector requests, models the host acknowledge and
// compares the hub against a cycle model on every clock

`timescale 1ns/1ps
`default_nettype none

`include "apple2_disk_settings.svh"

module tb_apple2_disk_hub;

	localparam int CLK_HALF    = 4;
	localparam int N_DIRECTED  = 16;
	localparam int N_RAND      = 300;
	localparam int ACK_DLY_MIN = 2;
	localparam int ACK_DLY_MAX = 9;
	localparam int ACK_HLD_MIN = 1;
	localparam int ACK_HLD_MAX = 4;
	// Strobe latency, slowest host and the return to idle
	localparam int XFER_MAX    = 2 + ACK_DLY_MAX + ACK_HLD_MAX + 3;
	// Each request may queue behind one transfer on its drive
	localparam int TIMEOUT_CYC = (N_DIRECTED + N_RAND) * 2 * XFER_MAX + 500;

	logic                       clk_sys = 1'b0;
	logic                       dd_reset;
	logic                       cpu_req_read;
	logic                       cpu_req_write;
	apple2_disk_pkg::drv_idx_t  cpu_req_drive;
	apple2_disk_pkg::lba_t      cpu_req_lba;
	apple2_disk_pkg::drv_vec_t  img_mounted;
	apple2_disk_pkg::img_size_t img_size;
	logic                       img_readonly;
	apple2_disk_pkg::drv_vec_t  sd_ack = '0;
	wire apple2_disk_pkg::drv_vec_t sd_rd;
	wire apple2_disk_pkg::drv_vec_t sd_wr;
	wire apple2_disk_pkg::lba_t     sd_lba;
	wire                            cpu_wait;
	wire                            disk_active;
	wire                            req_reject;
	wire apple2_disk_pkg::drv_vec_t drive_mounted;
	wire apple2_disk_pkg::drv_vec_t drive_protect;
	wire apple2_disk_pkg::drv_vec_t drive_change;

	int seed      = 59;
	int ack_seed  = 59;
	int errors    = 0;
	int checks    = 0;
	int accepted  = 0;
	int rejected  = 0;
	int transfers = 0;

	// Cycle model state
	apple2_disk_pkg::drv_vec_t m_mounted;
	apple2_disk_pkg::drv_vec_t m_protect;
	apple2_disk_pkg::drv_vec_t m_change;
	apple2_disk_pkg::drv_vec_t m_prd;
	apple2_disk_pkg::drv_vec_t m_pwr;
	apple2_disk_pkg::drv_vec_t m_pend_rd;
	apple2_disk_pkg::drv_vec_t m_pend_wr;
	apple2_disk_pkg::drv_vec_t m_srd;
	apple2_disk_pkg::drv_vec_t m_swr;
	apple2_disk_pkg::drv_vec_t m_xfer;
	apple2_disk_pkg::drv_vec_t m_old_ack;
	logic                      m_reject;
	apple2_disk_pkg::lba_t     m_slot [`NUM_DRIVES];

	// Accepted requests per drive still waiting for the host to take a strobe
	apple2_disk_pkg::drv_vec_t owed_rd;
	apple2_disk_pkg::drv_vec_t owed_wr;
	apple2_disk_pkg::drv_vec_t prev_rd = '0;
	apple2_disk_pkg::drv_vec_t prev_wr = '0;

	// Host acknowledge model state
	int h_state [`NUM_DRIVES];
	int h_count [`NUM_DRIVES];

	always #CLK_HALF clk_sys = ~clk_sys;

	apple2_disk_hub dut (
		.clk_sys       (clk_sys),
		.dd_reset      (dd_reset),
		.cpu_req_read  (cpu_req_read),
		.cpu_req_write (cpu_req_write),
		.cpu_req_drive (cpu_req_drive),
		.cpu_req_lba   (cpu_req_lba),
		.img_mounted   (img_mounted),
		.img_size      (img_size),
		.img_readonly  (img_readonly),
		.sd_ack        (sd_ack),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.sd_lba        (sd_lba),
		.cpu_wait      (cpu_wait),
		.disk_active   (disk_active),
		.req_reject    (req_reject),
		.drive_mounted (drive_mounted),
		.drive_protect (drive_protect),
		.drive_change  (drive_change)
	);

	function automatic int rand_range(inout int s, input int lo, input int hi);
		return lo + int'($unsigned($random(s)) % (hi - lo + 1));
	endfunction

	// A mounted drive takes reads, and writes only when the image is writable
	function automatic logic req_accepted(input logic is_write, input logic mounted,
			input logic protect);
		return mounted && !(is_write && protect);
	endfunction

	// Acknowledged drive first, then a requesting one, lowest number wins
	function automatic apple2_disk_pkg::lba_t expected_lba(
			input apple2_disk_pkg::drv_vec_t ack,
			input apple2_disk_pkg::drv_vec_t strobe);
		for (int i = 0; i < `NUM_DRIVES; i++) begin
			if (ack[i]) begin
				return m_slot[i];
			end
		end
		for (int i = 0; i < `NUM_DRIVES; i++) begin
			if (strobe[i]) begin
				return m_slot[i];
			end
		end
		return '0;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] exp,
			input logic [63:0] got);
		errors++;
		$display("FAIL t=%0t: %s expected %0h got %0h", $time, what, exp, got);
	endtask

	task automatic cpu_request(input logic is_write, input int drv,
			input apple2_disk_pkg::lba_t lba);
		cpu_req_read  <= !is_write;
		cpu_req_write <= is_write;
		cpu_req_drive <= apple2_disk_pkg::drv_idx_t'(drv);
		cpu_req_lba   <= lba;
		@(posedge clk_sys);
		cpu_req_read  <= 1'b0;
		cpu_req_write <= 1'b0;
	endtask

	task automatic mount_image(input int drv, input apple2_disk_pkg::img_size_t size,
			input logic ro);
		img_mounted  <= apple2_disk_pkg::drv_vec_t'(1) << drv;
		img_size     <= size;
		img_readonly <= ro;
		@(posedge clk_sys);
		img_mounted  <= '0;
	endtask

	// Lets a request reach its channel, then waits for the hub to settle
	task automatic wait_idle();
		repeat (2) @(posedge clk_sys);
		while (disk_active || (sd_ack != '0))
			@(posedge clk_sys);
	endtask

	// ========================================================================
	// Host acknowledge model
	// ========================================================================

	always @(posedge clk_sys) begin
		if (dd_reset) begin
			sd_ack <= '0;
			for (int i = 0; i < `NUM_DRIVES; i++) begin
				h_state[i] = 0;
				h_count[i] = 0;
			end
		end else begin
			for (int i = 0; i < `NUM_DRIVES; i++) begin
				case (h_state[i])
					0: begin
						if (sd_rd[i] || sd_wr[i]) begin
							h_count[i] = rand_range(ack_seed, ACK_DLY_MIN, ACK_DLY_MAX);
							h_state[i] = 1;
						end
					end
					1: begin
						if (h_count[i] <= 1) begin
							sd_ack[i] <= 1'b1;
							h_count[i] = rand_range(ack_seed, ACK_HLD_MIN, ACK_HLD_MAX);
							h_state[i] = 2;
						end else begin
							h_count[i]--;
						end
					end
					default: begin
						if (h_count[i] <= 1) begin
							sd_ack[i] <= 1'b0;
							h_state[i] = 0;
						end else begin
							h_count[i]--;
						end
					end
				endcase
			end
		end
	end

	// ========================================================================
	// Cycle model of router and channels
	// ========================================================================

	always @(posedge clk_sys) begin : model_step
		logic rise;
		logic fall;
		logic acc;

		if (dd_reset) begin
			{m_mounted, m_protect, m_change} = '0;
			{m_prd, m_pwr, m_pend_rd, m_pend_wr} = '0;
			{m_srd, m_swr, m_xfer, m_old_ack} = '0;
			{owed_rd, owed_wr} = '0;
			m_reject = 1'b0;
		end else begin
			// Channels see the pulses registered last cycle
			for (int i = 0; i < `NUM_DRIVES; i++) begin
				rise = sd_ack[i] && !m_old_ack[i];
				fall = !sd_ack[i] && m_old_ack[i];

				// A strobe taken by the host serves every request merged into it
				if (rise && sd_rd[i]) begin
					owed_rd[i] = 1'b0;
				end
				if (rise && sd_wr[i]) begin
					owed_wr[i] = 1'b0;
				end
				owed_rd[i] = owed_rd[i] | m_prd[i];
				owed_wr[i] = owed_wr[i] | m_pwr[i];

				if (!m_xfer[i]) begin
					if (m_pend_rd[i] || m_pend_wr[i] || m_prd[i] || m_pwr[i]) begin
						m_srd[i]  = m_pend_rd[i] | m_prd[i];
						m_swr[i]  = m_pend_wr[i] | m_pwr[i];
						m_xfer[i] = 1'b1;
					end
					m_pend_rd[i] = m_pend_rd[i] | m_prd[i];
					m_pend_wr[i] = m_pend_wr[i] | m_pwr[i];
				end else if (rise) begin
					// Host took the strobed kinds so newer requests stay
					m_pend_rd[i] = m_prd[i] | (m_pend_rd[i] & ~m_srd[i]);
					m_pend_wr[i] = m_pwr[i] | (m_pend_wr[i] & ~m_swr[i]);
					m_srd[i] = 1'b0;
					m_swr[i] = 1'b0;
				end else begin
					if (fall) begin
						m_xfer[i] = 1'b0;
					end
					m_pend_rd[i] = m_pend_rd[i] | m_prd[i];
					m_pend_wr[i] = m_pend_wr[i] | m_pwr[i];
				end
				m_old_ack[i] = sd_ack[i];
			end

			// Request check uses the mount state from before this edge
			acc = 1'b0;
			if (int'(cpu_req_drive) < `NUM_DRIVES) begin
				acc = req_accepted(cpu_req_write, m_mounted[cpu_req_drive],
					m_protect[cpu_req_drive]);
			end
			m_prd    = '0;
			m_pwr    = '0;
			m_reject = 1'b0;
			if (cpu_req_read || cpu_req_write) begin
				if (acc) begin
					m_prd[cpu_req_drive]  = cpu_req_read;
					m_pwr[cpu_req_drive]  = cpu_req_write;
					m_slot[cpu_req_drive] = cpu_req_lba;
					accepted++;
				end else begin
					m_reject = 1'b1;
					rejected++;
				end
			end

			for (int i = 0; i < `NUM_DRIVES; i++) begin
				if (img_mounted[i]) begin
					m_mounted[i] = (img_size != '0);
					m_protect[i] = img_readonly;
					m_change[i]  = !m_change[i];
				end
			end
		end
	end

	// ========================================================================
	// Checker on the falling edge where outputs are stable
	// ========================================================================

	always @(negedge clk_sys) begin : check_outputs
		apple2_disk_pkg::lba_t exp_lba;

		checks++;
		if (sd_rd !== m_srd) begin
			report_mismatch("sd_rd", 64'(m_srd), 64'(sd_rd));
		end
		if (sd_wr !== m_swr) begin
			report_mismatch("sd_wr", 64'(m_swr), 64'(sd_wr));
		end
		if (cpu_wait !== (|m_xfer)) begin
			report_mismatch("cpu_wait", 64'(|m_xfer), 64'(cpu_wait));
		end
		if (disk_active !== (|(m_xfer | m_pend_rd | m_pend_wr))) begin
			report_mismatch("disk_active", 64'(|(m_xfer | m_pend_rd | m_pend_wr)),
				64'(disk_active));
		end
		if (req_reject !== m_reject) begin
			report_mismatch("req_reject", 64'(m_reject), 64'(req_reject));
		end
		if (drive_mounted !== m_mounted) begin
			report_mismatch("drive_mounted", 64'(m_mounted), 64'(drive_mounted));
		end
		if (drive_protect !== m_protect) begin
			report_mismatch("drive_protect", 64'(m_protect), 64'(drive_protect));
		end
		if (drive_change !== m_change) begin
			report_mismatch("drive_change", 64'(m_change), 64'(drive_change));
		end
		exp_lba = expected_lba(sd_ack, m_srd | m_swr);
		if (sd_lba !== exp_lba) begin
			report_mismatch("sd_lba", 64'(exp_lba), 64'(sd_lba));
		end

		// Every new host strobe must answer an accepted request
		if ((sd_rd & ~prev_rd & ~owed_rd) != '0) begin
			errors++;
			$display("FAIL t=%0t: sd_rd rose with no accepted read waiting", $time);
		end
		if ((sd_wr & ~prev_wr & ~owed_wr) != '0) begin
			errors++;
			$display("FAIL t=%0t: sd_wr rose with no accepted write waiting", $time);
		end
		transfers += $countones((sd_rd | sd_wr) & ~(prev_rd | prev_wr));
		prev_rd = sd_rd;
		prev_wr = sd_wr;
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin : stimulus
		apple2_disk_pkg::img_size_t size;

		dd_reset      <= 1'b1;
		cpu_req_read  <= 1'b0;
		cpu_req_write <= 1'b0;
		cpu_req_drive <= '0;
		cpu_req_lba   <= '0;
		img_mounted   <= '0;
		img_size      <= '0;
		img_readonly  <= 1'b0;
		repeat (5) @(posedge clk_sys);
		dd_reset <= 1'b0;
		@(posedge clk_sys);

		// Floppy 1 writable, hard disk read-only, floppy 2 empty
		mount_image(0, 64'd143360, 1'b0);
		mount_image(1, 64'd33554432, 1'b1);
		mount_image(2, '0, 1'b0);
		cpu_request(1'b1, 1, 32'h0000_0010);
		cpu_request(1'b0, 2, 32'h0000_0020);
		cpu_request(1'b1, 3, 32'h0000_0030);
		wait_idle();

		cpu_request(1'b0, 0, 32'h0000_0100);
		wait_idle();
		cpu_request(1'b0, 1, 32'h0000_2000);
		wait_idle();
		cpu_request(1'b1, 0, 32'h0000_0101);
		wait_idle();

		// Several drives in flight, plus requests merged into busy channels
		mount_image(2, 64'd143360, 1'b0);
		cpu_request(1'b0, 0, 32'h0000_0200);
		cpu_request(1'b1, 2, 32'h0000_0300);
		cpu_request(1'b0, 1, 32'h0000_0400);
		cpu_request(1'b1, 0, 32'h0000_0201);
		cpu_request(1'b0, 0, 32'h0000_0202);
		wait_idle();

		// Zero size ejects the hard disk
		mount_image(1, '0, 1'b0);
		cpu_request(1'b0, 1, 32'h0000_0500);
		wait_idle();

		for (int n = 0; n < N_RAND; n++) begin
			if (rand_range(seed, 0, 15) == 0) begin
				if (rand_range(seed, 0, 3) == 0) begin
					size = '0;
				end else begin
					size = apple2_disk_pkg::img_size_t'(rand_range(seed, 1, 4096)) * 64'd512;
				end
				mount_image(rand_range(seed, 0, 2), size, rand_range(seed, 0, 1) == 1);
			end
			cpu_request(rand_range(seed, 0, 2) == 0, rand_range(seed, 0, 3),
				apple2_disk_pkg::lba_t'($random(seed)));
			repeat (rand_range(seed, 0, 3)) @(posedge clk_sys);
		end
		wait_idle();
		repeat (2) @(negedge clk_sys);

		if ((owed_rd | owed_wr) != '0) begin
			errors++;
			$display("An accepted request never got its host strobe taken");
		end
		$display("Summary: %0d checks, %0d accepted, %0d rejected, %0d transfers, %0d errors",
			checks, accepted, rejected, transfers, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_CYC * 2 * CLK_HALF);
		$display("Timeout: the run did not finish in the expected time");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/apple2_disk_hub.sv
// Apple II disk hub top level
// Status router feeding one request channel per drive, drained toward the
// host through the sector address multiplexer

`timescale 1ns/1ps
`default_nettype none

`include "apple2_disk_settings.svh"

module apple2_disk_hub (
	input  wire                              clk_sys,
	input  wire                              dd_reset,
	// CPU side
	input  wire                              cpu_req_read,
	input  wire                              cpu_req_write,
	input  wire apple2_disk_pkg::drv_idx_t   cpu_req_drive,
	input  wire apple2_disk_pkg::lba_t       cpu_req_lba,
	// Host side
	input  wire apple2_disk_pkg::drv_vec_t   img_mounted,
	input  wire apple2_disk_pkg::img_size_t  img_size,
	input  wire                              img_readonly,
	input  wire apple2_disk_pkg::drv_vec_t   sd_ack,
	output wire apple2_disk_pkg::drv_vec_t   sd_rd,
	output wire apple2_disk_pkg::drv_vec_t   sd_wr,
	output wire apple2_disk_pkg::lba_t       sd_lba,
	// Status
	output wire                              cpu_wait,
	output wire                              disk_active,
	output wire                              req_reject,
	output wire apple2_disk_pkg::drv_vec_t   drive_mounted,
	output wire apple2_disk_pkg::drv_vec_t   drive_protect,
	output wire apple2_disk_pkg::drv_vec_t   drive_change
);

	wire apple2_disk_pkg::drv_vec_t read_pulse;
	wire apple2_disk_pkg::drv_vec_t write_pulse;
	wire apple2_disk_pkg::drv_vec_t chan_wait;
	wire apple2_disk_pkg::drv_vec_t chan_pending;
	wire apple2_disk_pkg::lba_t     req_lba [`NUM_DRIVES];

	// ============================================================================
	// Mount state and request decode
	// ============================================================================

	drive_status_router u_router (
		.clk_sys       (clk_sys),
		.dd_reset      (dd_reset),
		.img_mounted   (img_mounted),
		.img_size      (img_size),
		.img_readonly  (img_readonly),
		.cpu_req_read  (cpu_req_read),
		.cpu_req_write (cpu_req_write),
		.cpu_req_drive (cpu_req_drive),
		.cpu_req_lba   (cpu_req_lba),
		.read_pulse    (read_pulse),
		.write_pulse   (write_pulse),
		.drive_mounted (drive_mounted),
		.drive_protect (drive_protect),
		.drive_change  (drive_change),
		.req_lba       (req_lba),
		.req_reject    (req_reject)
	);

	// ============================================================================
	// One handshake channel per drive
	// ============================================================================

	for (genvar i = 0; i < `NUM_DRIVES; i++) begin : g_chan
		drive_request_channel u_chan (
			.clk_sys     (clk_sys),
			.dd_reset    (dd_reset),
			.read_pulse  (read_pulse[i]),
			.write_pulse (write_pulse[i]),
			.sd_ack      (sd_ack[i]),
			.sd_rd       (sd_rd[i]),
			.sd_wr       (sd_wr[i]),
			.busy_wait   (chan_wait[i]),
			.pending     (chan_pending[i])
		);
	end

	// ============================================================================
	// Host address select and status
	// ============================================================================

	sd_host_mux u_mux (
		.sd_ack       (sd_ack),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.chan_wait    (chan_wait),
		.chan_pending (chan_pending),
		.req_lba      (req_lba),
		.sd_lba       (sd_lba),
		.cpu_wait     (cpu_wait),
		.disk_active  (disk_active)
	);

endmodule

`default_nettype wire

// File: rtl/apple2_disk_pkg.sv
// Apple II disk hub shared types
// Named-width types for sector addresses, drive numbers and drive vectors

`default_nettype none

`include "apple2_disk_settings.svh"

package apple2_disk_pkg;

	// Sector address as seen by the host
	typedef logic [`LBA_W-1:0] lba_t;

	// Drive number carried with a CPU request
	typedef logic [`DRV_IDX_W-1:0] drv_idx_t;

	// One bit per virtual drive
	typedef logic [`NUM_DRIVES-1:0] drv_vec_t;

	// Mounted image size in bytes
	typedef logic [`IMG_SIZE_W-1:0] img_size_t;

endpackage

`default_nettype wire

// File: rtl/apple2_disk_settings.svh
// Apple II disk hub build constants
// Drive count and the widths of the host-side block device buses

`ifndef APPLE2_DISK_SETTINGS_SVH
`define APPLE2_DISK_SETTINGS_SVH

// ============================================================================
// Drive configuration
// ============================================================================

// Floppy 1, hard disk, floppy 2
`define NUM_DRIVES 3

// Wide enough to number every drive
`define DRV_IDX_W 2

// ============================================================================
// Host bus widths
// ============================================================================

// Sector address toward the host
`define LBA_W 32

// Image size reported with a mount strobe, in bytes
`define IMG_SIZE_W 64

`endif

// File: rtl/drive_request_channel.sv
// Drive request channel
// Latches pending reads and writes for one drive and runs the host strobe
// handshake, clearing on the rising acknowledge and finishing on the falling one

`timescale 1ns/1ps
`default_nettype none

module drive_request_channel (
	input  wire  clk_sys,
	input  wire  dd_reset,
	input  wire  read_pulse,
	input  wire  write_pulse,
	input  wire  sd_ack,
	output logic sd_rd,
	output logic sd_wr,
	output logic busy_wait,
	output logic pending
);

	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_XFER = 1'b1;

	logic xfer_state;
	logic old_ack;
	logic rd_pend;
	logic wr_pend;
	logic ack_rise;
	logic ack_fall;
	logic any_req;

	// Edges against the copy of sd_ack from the previous cycle
	assign ack_rise = ~old_ack & sd_ack;
	assign ack_fall = old_ack & ~sd_ack;

	// A pulse arriving this cycle counts as pending already
	assign any_req = rd_pend | wr_pend | read_pulse | write_pulse;

	assign pending = rd_pend | wr_pend;

	// ============================================================================
	// Handshake FSM
	// ============================================================================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			xfer_state <= ST_IDLE;
			old_ack    <= 1'b0;
			rd_pend    <= 1'b0;
			wr_pend    <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			busy_wait  <= 1'b0;
		end else begin
			old_ack <= sd_ack;
			rd_pend <= rd_pend | read_pulse;
			wr_pend <= wr_pend | write_pulse;

			case (xfer_state)
				ST_IDLE: begin
					// Both strobes rise together if both kinds are waiting
					if (any_req) begin
						xfer_state <= ST_XFER;
						sd_rd      <= rd_pend | read_pulse;
						sd_wr      <= wr_pend | write_pulse;
						busy_wait  <= 1'b1;
					end
				end
				ST_XFER: begin
					if (ack_rise) begin
						// Host took the strobed kinds so only the others stay pending
						rd_pend <= read_pulse | (rd_pend & ~sd_rd);
						wr_pend <= write_pulse | (wr_pend & ~sd_wr);
						sd_rd   <= 1'b0;
						sd_wr   <= 1'b0;
					end else if (ack_fall) begin
						xfer_state <= ST_IDLE;
						busy_wait  <= 1'b0;
					end
				end
				default: begin
					xfer_state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/drive_status_router.sv
// Drive status router
// Tracks mount and write-protect state per drive, checks CPU requests
// against it and turns accepted ones into per-drive pulses plus a sector slot

`timescale 1ns/1ps
`default_nettype none

`include "apple2_disk_settings.svh"

module drive_status_router (
	input  wire                              clk_sys,
	input  wire                              dd_reset,
	input  wire apple2_disk_pkg::drv_vec_t   img_mounted,
	input  wire apple2_disk_pkg::img_size_t  img_size,
	input  wire                              img_readonly,
	input  wire                              cpu_req_read,
	input  wire                              cpu_req_write,
	input  wire apple2_disk_pkg::drv_idx_t   cpu_req_drive,
	input  wire apple2_disk_pkg::lba_t       cpu_req_lba,
	output apple2_disk_pkg::drv_vec_t        read_pulse,
	output apple2_disk_pkg::drv_vec_t        write_pulse,
	output apple2_disk_pkg::drv_vec_t        drive_mounted,
	output apple2_disk_pkg::drv_vec_t        drive_protect,
	output apple2_disk_pkg::drv_vec_t        drive_change,
	output apple2_disk_pkg::lba_t            req_lba [`NUM_DRIVES],
	output logic                             req_reject
);

	// ============================================================================
	// Request decode
	// ============================================================================

	apple2_disk_pkg::drv_vec_t drv_sel;
	logic                      sel_mounted;
	logic                      sel_protect;
	logic                      accept_rd;
	logic                      accept_wr;
	logic                      refuse;

	// One-hot drive select where an out-of-range drive number selects nothing
	always_comb begin
		for (int i = 0; i < `NUM_DRIVES; i++) begin
			drv_sel[i] = (cpu_req_drive == apple2_disk_pkg::drv_idx_t'(i));
		end
	end

	// Checked against the state registered before this cycle
	assign sel_mounted = |(drv_sel & drive_mounted);
	assign sel_protect = |(drv_sel & drive_protect);

	assign accept_rd = cpu_req_read & sel_mounted;
	assign accept_wr = cpu_req_write & sel_mounted & ~sel_protect;

	// Empty drive, or write to a read-only image
	assign refuse = (cpu_req_read | cpu_req_write) & ~(accept_rd | accept_wr);

	// ============================================================================
	// Mount tracking
	// ============================================================================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			drive_mounted <= '0;
			drive_protect <= '0;
			drive_change  <= '0;
		end else begin
			for (int i = 0; i < `NUM_DRIVES; i++) begin
				if (img_mounted[i]) begin
					drive_mounted[i] <= (img_size != '0);
					drive_protect[i] <= img_readonly;
					// Toggles on every mount so the consumer sees a new image
					drive_change[i]  <= ~drive_change[i];
				end
			end
		end
	end

	// ============================================================================
	// Request pulses
	// ============================================================================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			read_pulse  <= '0;
			write_pulse <= '0;
			req_reject  <= 1'b0;
		end else begin
			read_pulse  <= drv_sel & {`NUM_DRIVES{accept_rd}};
			write_pulse <= drv_sel & {`NUM_DRIVES{accept_wr}};
			req_reject  <= refuse;
		end
	end

	// Sector slot per drive written only by an accepted request
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < `NUM_DRIVES; i++) begin
			if (drv_sel[i] & (accept_rd | accept_wr)) begin
				req_lba[i] <= cpu_req_lba;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/sd_host_mux.sv
// Host-side multiplexer
// Picks the sector address shown to the host and combines the channel
// wait and pending flags into the CPU wait and the activity output

`timescale 1ns/1ps
`default_nettype none

`include "apple2_disk_settings.svh"

module sd_host_mux (
	input  wire apple2_disk_pkg::drv_vec_t  sd_ack,
	input  wire apple2_disk_pkg::drv_vec_t  sd_rd,
	input  wire apple2_disk_pkg::drv_vec_t  sd_wr,
	input  wire apple2_disk_pkg::drv_vec_t  chan_wait,
	input  wire apple2_disk_pkg::drv_vec_t  chan_pending,
	input  wire apple2_disk_pkg::lba_t      req_lba [`NUM_DRIVES],
	output apple2_disk_pkg::lba_t           sd_lba,
	output logic                            cpu_wait,
	output logic                            disk_active
);

	apple2_disk_pkg::drv_vec_t strobe;
	logic                      ack_found;
	logic                      strobe_found;

	assign strobe = sd_rd | sd_wr;

	// ============================================================================
	// Sector address select
	// ============================================================================

	// The host reads the address while acknowledging, so an acknowledged
	// drive wins over one that is only requesting. Lowest drive first
	always_comb begin
		apple2_disk_pkg::lba_t ack_lba;
		apple2_disk_pkg::lba_t strobe_lba;

		ack_lba      = '0;
		strobe_lba   = '0;
		ack_found    = 1'b0;
		strobe_found = 1'b0;

		for (int i = 0; i < `NUM_DRIVES; i++) begin
			if (sd_ack[i] && !ack_found) begin
				ack_lba   = req_lba[i];
				ack_found = 1'b1;
			end
			if (strobe[i] && !strobe_found) begin
				strobe_lba   = req_lba[i];
				strobe_found = 1'b1;
			end
		end

		if (ack_found) begin
			sd_lba = ack_lba;
		end else if (strobe_found) begin
			sd_lba = strobe_lba;
		end else begin
			sd_lba = '0;
		end
	end

	// ============================================================================
	// Status
	// ============================================================================

	assign cpu_wait    = |chan_wait;
	assign disk_active = |(chan_wait | chan_pending);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the disk hub testbench with Verilator and runs it.
# Exits nonzero if the build, the run or the pass check fails.

cd "$(dirname "$0")" || exit 1

TOP=tb_apple2_disk_hub
OBJ_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator was not found in PATH"
	exit 1
fi

# Binary mode compiles the simulator executable in one step
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module "$TOP" --Mdir "$OBJ_DIR" -f apple2_disk_hub.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$("./$OBJ_DIR/V$TOP" 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The result comes from the testbench's own verdict line
if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	echo "Result: pass"
	exit 0
fi

echo "Result: fail"
exit 1
